/* src/bus_pkg.sv */
// ----------------------------------------------------------------------
// board bus transport types shared by the hosts, the arbiter and banks
// ----------------------------------------------------------------------

package bus_pkg;

    // ------------------------------------------------------------------
    // host ports
    // ------------------------------------------------------------------
    localparam int HOST_COUNT = 2;          // 0 = firewire side, 1 = ethernet side

    typedef logic [0:0]  host_id_t;         // index of a host port
    typedef logic [15:0] addr_t;            // register address
    typedef logic [31:0] data_t;            // register data word

    // ------------------------------------------------------------------
    // bus payloads
    // ------------------------------------------------------------------
    // request issued by the arbiter to every bank, valid for one cycle
    typedef struct packed {
        logic  valid;                       // request present this cycle
        logic  we;                          // 1 -> write, 0 -> read
        addr_t addr;                        // region + register index
        data_t wdata;                       // write data, ignored on read
    } bus_req_t;

    // wishbone classic inputs of one host port
    typedef struct packed {
        logic  cyc;                         // bus cycle in progress
        logic  stb;                         // transfer strobe
        logic  we;                          // write enable
        addr_t adr;                         // register address
        data_t dat;                         // write data
    } wb_port_t;

endpackage

/* src/addr_map_pkg.sv */
// ----------------------------------------------------------------------
// board register address map, region and index fields
// ----------------------------------------------------------------------

package addr_map_pkg;

    // ------------------------------------------------------------------
    // address layout
    //   [15:12] region  (one register bank per region)
    //   [11:8]  ignored
    //   [7:0]   register index, upper bits unused for small banks
    // ------------------------------------------------------------------
    localparam int REGION_W      = 4;       // region field width
    localparam int REGION_LSB    = 12;      // region sits in the top nibble
    localparam int REG_IDX_MAX_W = 8;       // widest index the map allows

    typedef logic [REGION_W-1:0] region_t;  // region number

endpackage

/* src/host_arbiter.sv */
// ----------------------------------------------------------------------
// wishbone host ports with fixed priority grant, host 0 first;
// issues one request to the banks and holds the bus until done
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module host_arbiter
    import bus_pkg::*;
(
    input  logic     sysclk,
    input  logic     arst_n,
    input  wb_port_t host_in [HOST_COUNT],  // wishbone inputs per host
    input  logic     done,                  // transaction finished, from read_return
    output bus_req_t bus_req,               // request to all banks
    output logic     issued,                // request on the bus this cycle
    output host_id_t grant_id               // host that owns the bus
);

    typedef enum logic [1:0] {
        IDLE,                               // waiting for a host strobe
        ISSUE,                              // request on the bus
        WAIT_ACK                            // bank busy, waiting for done
    } arb_state_t;

    arb_state_t state;
    logic       req_any;                    // some host has cyc and stb up
    host_id_t   pick;                       // winner of this idle sample

    logic       req_valid;
    logic       req_we;
    addr_t      req_addr;
    data_t      req_wdata;

    // ------------------------------------------------------------------
    // fixed priority pick, lowest index wins
    // ------------------------------------------------------------------
    always_comb
    begin
        req_any = 1'b0;
        pick    = '0;
        for (int h = HOST_COUNT - 1; h >= 0; h--)  // walk down so host 0 wins last
        begin
            if (host_in[h].cyc && host_in[h].stb)
            begin
                req_any = 1'b1;
                pick    = host_id_t'(h);
            end
        end
    end

    // ------------------------------------------------------------------
    // grant state machine
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= IDLE;
            req_valid <= 1'b0;
            grant_id  <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req_any)
                    begin
                        state     <= ISSUE;
                        req_valid <= 1'b1;  // one cycle on the bus
                        grant_id  <= pick;  // held until done
                    end
                end
                ISSUE:
                begin
                    state     <= WAIT_ACK;
                    req_valid <= 1'b0;
                end
                WAIT_ACK:
                begin
                    if (done)
                        state <= IDLE;      // next request sampled one edge later
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // payload capture, only meaningful while req_valid is high
    always_ff @(posedge sysclk)
    begin
        if (state == IDLE && req_any)
        begin
            req_we    <= host_in[pick].we;
            req_addr  <= host_in[pick].adr;
            req_wdata <= host_in[pick].dat;
        end
    end

    assign bus_req = '{valid: req_valid, we: req_we, addr: req_addr, wdata: req_wdata};
    assign issued  = req_valid;             // marker follows the bus request

endmodule

/* src/reg_bank.sv */
// ----------------------------------------------------------------------
// register file of one address region, registered write and read
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module reg_bank
    import bus_pkg::*, addr_map_pkg::*;
#(
    parameter int BANK_ID       = 0,        // region this bank answers
    parameter int REGS_PER_BANK = 8         // power of two, up to 256
)
(
    input  logic     sysclk,
    input  logic     arst_n,
    input  bus_req_t bus_req,               // shared request from the arbiter
    output data_t    rdata                  // read word, zero when not read
);

    localparam int IDX_W = (REGS_PER_BANK > 1) ? $clog2(REGS_PER_BANK) : 1;

    data_t                    regs [REGS_PER_BANK];
    region_t                  region;       // region field of the address
    logic [REG_IDX_MAX_W-1:0] idx_full;     // full index field
    logic [IDX_W-1:0]         idx;          // index modulo bank size
    logic                     hit;          // request claimed by this bank

    // ------------------------------------------------------------------
    // local address decode
    // ------------------------------------------------------------------
    assign region   = bus_req.addr[REGION_LSB +: REGION_W];
    assign idx_full = bus_req.addr[REG_IDX_MAX_W-1:0];
    assign idx      = idx_full[IDX_W-1:0];  // bits above the bank size are dropped
    assign hit      = bus_req.valid && (region == region_t'(BANK_ID));

    // ------------------------------------------------------------------
    // register file, every register reads zero after reset
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < REGS_PER_BANK; i++)
                regs[i] <= '0;
            rdata <= '0;
        end
        else
        begin
            rdata <= '0;                    // idle banks drive zero into the OR merge
            if (hit)
            begin
                if (bus_req.we)
                    regs[idx] <= bus_req.wdata;
                else
                    rdata <= regs[idx];     // one cycle read latency
            end
        end
    end

endmodule

/* src/read_return.sv */
// ----------------------------------------------------------------------
// merges bank read words and returns ack and data to the granted host
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module read_return
    import bus_pkg::*;
#(
    parameter int NUM_BANKS = 4             // number of mapped regions
)
(
    input  logic                  sysclk,
    input  logic                  arst_n,
    input  logic                  issued,       // request on the bus
    input  host_id_t              grant_id,     // owner of the request
    input  data_t                 bank_rdata [NUM_BANKS],
    output logic [HOST_COUNT-1:0] host_ack,     // one cycle per transaction
    output data_t                 host_dat [HOST_COUNT],
    output logic                  done          // releases the arbiter
);

    logic     issued_q;                     // matches the bank latency
    host_id_t grant_q;
    data_t    merged;                       // OR of all bank read words

    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            issued_q <= 1'b0;
            grant_q  <= '0;
        end
        else
        begin
            issued_q <= issued;
            grant_q  <= grant_id;
        end
    end

    // ------------------------------------------------------------------
    // read mux, unselected banks hold zero so an OR is enough
    // ------------------------------------------------------------------
    always_comb
    begin
        merged = '0;
        for (int b = 0; b < NUM_BANKS; b++)
            merged = merged | bank_rdata[b];
    end

    // unmapped regions still ack, with zero data
    always_comb
    begin
        for (int h = 0; h < HOST_COUNT; h++)
        begin
            host_ack[h] = issued_q && (grant_q == host_id_t'(h));
            host_dat[h] = host_ack[h] ? merged : '0;
        end
    end

    assign done = issued_q;

endmodule

/* src/board_bus_top.sv */
// ----------------------------------------------------------------------
// board register bus: two wishbone hosts, priority arbiter,
// one register bank per region and the read return stage
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module board_bus_top
    import bus_pkg::*;
#(
    parameter int NUM_BANKS     = 4,        // mapped regions, 1 to 16
    parameter int REGS_PER_BANK = 8         // registers in each bank
)
(
    input  logic                  sysclk,
    input  logic                  arst_n,
    input  wb_port_t              host_in [HOST_COUNT],
    output logic [HOST_COUNT-1:0] host_ack,
    output data_t                 host_dat [HOST_COUNT]
);

    bus_req_t bus_req;                      // shared request to the banks
    logic     issued;
    logic     done;
    host_id_t grant_id;
    data_t    bank_rdata [NUM_BANKS];       // one read word per bank

    host_arbiter u_arbiter (
        .sysclk   (sysclk),
        .arst_n   (arst_n),
        .host_in  (host_in),
        .done     (done),
        .bus_req  (bus_req),
        .issued   (issued),
        .grant_id (grant_id)
    );

    // ------------------------------------------------------------------
    // register banks, one per region
    // ------------------------------------------------------------------
    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_bank
        reg_bank #(
            .BANK_ID       (b),
            .REGS_PER_BANK (REGS_PER_BANK)
        ) u_bank (
            .sysclk  (sysclk),
            .arst_n  (arst_n),
            .bus_req (bus_req),
            .rdata   (bank_rdata[b])
        );
    end

    read_return #(
        .NUM_BANKS (NUM_BANKS)
    ) u_return (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .issued     (issued),
        .grant_id   (grant_id),
        .bank_rdata (bank_rdata),
        .host_ack   (host_ack),
        .host_dat   (host_dat),
        .done       (done)
    );

endmodule

/* testbench/tb_clock_gen.sv */
// ----------------------------------------------------------------------
// testbench clock and reset, 40 ns period, reset held 10 cycles
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,        // clock period
    parameter int RESET_CYCLES = 10         // cycles with arst_n low
)
(
    output logic sysclk,
    output logic arst_n
);

    initial
    begin
        sysclk = 1'b0;
        forever #(PERIOD_NS / 2) sysclk = ~sysclk;
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        #2 arst_n = 1'b1;                   // release clear of the edge
    end

endmodule

/* testbench/tb_board_bus.sv */
// ----------------------------------------------------------------------
// directed tests of the board register bus against a register map model
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_board_bus
    import bus_pkg::*, addr_map_pkg::*;
;
    localparam int NUM_BANKS     = 4;
    localparam int REGS_PER_BANK = 8;
    localparam int DRIVE_DLY     = 2;       // ns after the rising edge
    localparam int ACK_TIMEOUT   = 20;      // cycles a host waits for ack
    localparam int RST_TIMEOUT   = 50;
    localparam int SEED          = 32'h361a_9344;

    logic                  sysclk;
    logic                  arst_n;
    wb_port_t              host_in [HOST_COUNT];
    logic [HOST_COUNT-1:0] host_ack;
    data_t                 host_dat [HOST_COUNT];

    data_t model [NUM_BANKS][REGS_PER_BANK]; // expected register contents
    int    error_count;
    int    check_count;
    int    test_count;

    tb_clock_gen u_clk (.sysclk(sysclk), .arst_n(arst_n));

    board_bus_top #(
        .NUM_BANKS     (NUM_BANKS),
        .REGS_PER_BANK (REGS_PER_BANK)
    ) dut (
        .sysclk   (sysclk),
        .arst_n   (arst_n),
        .host_in  (host_in),
        .host_ack (host_ack),
        .host_dat (host_dat)
    );

    // ------------------------------------------------------------------
    // register map model
    // ------------------------------------------------------------------
    function automatic addr_t make_addr(input int region, input int idx);
        return {region_t'(region), 4'h0, 8'(idx)};      // bits 11:8 left zero
    endfunction

    function automatic data_t model_read(input addr_t adr);
        int region;
        int idx;
        region = int'(adr[REGION_LSB +: REGION_W]);
        idx    = int'(adr[REG_IDX_MAX_W-1:0]) % REGS_PER_BANK;
        if (region >= NUM_BANKS)
            return '0;                      // unmapped region reads zero
        return model[region][idx];
    endfunction

    task automatic model_write(input addr_t adr, input data_t wdat);
        int region;
        int idx;
        region = int'(adr[REGION_LSB +: REGION_W]);
        idx    = int'(adr[REG_IDX_MAX_W-1:0]) % REGS_PER_BANK;
        if (region < NUM_BANKS)
            model[region][idx] = wdat;      // writes to unmapped regions vanish
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Error: %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // wishbone host transfer
    // edges counts the rising edges between drive and ack
    // ------------------------------------------------------------------
    task automatic bus_transfer(input int host, input logic we, input addr_t adr,
                                input data_t wdat, output data_t rdat, output int edges,
                                output time t_ack, output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        rdat   = '0;
        t_ack  = 0;
        @(posedge sysclk);
        #DRIVE_DLY;
        host_in[host] = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        while (!ok && cycles < ACK_TIMEOUT)
        begin
            @(negedge sysclk);              // ack is stable mid cycle
            if (host_ack[host])
            begin
                ok    = 1'b1;
                rdat  = host_dat[host];
                t_ack = $time;
            end
            else
                cycles++;
        end
        edges = cycles;
        if (!ok)
        begin
            error_count++;
            $display("timeout: host %0d saw no ack within %0d cycles, addr %h",
                     host, ACK_TIMEOUT, adr);
        end
        @(posedge sysclk);                  // host takes ack at this edge
        #DRIVE_DLY;
        host_in[host] = '0;
    endtask

    task automatic wb_write(input int host, input addr_t adr, input data_t wdat);
        data_t rdat;
        int    edges;
        time   t_ack;
        bit    ok;
        bus_transfer(host, 1'b1, adr, wdat, rdat, edges, t_ack, ok);
        if (ok)
            model_write(adr, wdat);
    endtask

    task automatic wb_read(input int host, input addr_t adr, output data_t rdat);
        int  edges;
        time t_ack;
        bit  ok;
        bus_transfer(host, 1'b0, adr, '0, rdat, edges, t_ack, ok);
    endtask

    task automatic read_check(input int host, input addr_t adr);
        data_t rdat;
        wb_read(host, adr, rdat);
        check_equal(rdat, model_read(adr), $sformatf("read host %0d addr %h", host, adr));
    endtask

    task automatic check_all_regs(input int host);
        for (int b = 0; b < NUM_BANKS; b++)
            for (int i = 0; i < REGS_PER_BANK; i++)
                read_check(host, make_addr(b, i));
    endtask

    task automatic finish_test(input string name, input int err_before);
        test_count++;
        $display("test %s finished, %0d errors", name, error_count - err_before);
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic test_reset_values();
        int err_before;
        err_before = error_count;
        for (int n = 0; n < 4; n++)
        begin
            @(negedge sysclk);
            check_equal(32'(host_ack), 32'd0, "ack high with no request");
        end
        check_all_regs(0);
        check_all_regs(1);
        finish_test("reset_values", err_before);
    endtask

    task automatic test_write_read_all();
        int    err_before;
        addr_t adr;
        err_before = error_count;
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            for (int i = 0; i < REGS_PER_BANK; i++)
            begin
                adr = make_addr(b, i);
                for (int w = 0; w < HOST_COUNT; w++)  // each host writes every register
                begin
                    wb_write(w, adr, $urandom);
                    read_check(1 - w, adr);
                end
            end
        end
        finish_test("write_read_all", err_before);
    endtask

    task automatic test_isolation();
        int err_before;
        int unmapped [2];
        err_before  = error_count;
        unmapped[0] = NUM_BANKS;            // first region past the banks
        unmapped[1] = 15;
        wb_write(0, make_addr(1, 3), $urandom);
        check_all_regs(1);
        wb_write(1, make_addr(2, 3 + REGS_PER_BANK), $urandom);  // index aliases to 3
        read_check(0, make_addr(2, 3));
        check_all_regs(0);
        for (int u = 0; u < 2; u++)
        begin
            wb_write(0, make_addr(unmapped[u], 5), $urandom);  // must still ack
            read_check(1, make_addr(unmapped[u], 5));
        end
        check_all_regs(0);
        finish_test("isolation", err_before);
    endtask

    task automatic test_arbitration();
        int    err_before;
        addr_t a0;
        addr_t a1;
        data_t d0;
        data_t d1;
        data_t r0;
        data_t r1;
        int    e0;
        int    e1;
        time   t0;
        time   t1;
        bit    ok0;
        bit    ok1;
        err_before = error_count;
        a0 = make_addr(0, 6);
        a1 = make_addr(3, 2);
        d0 = $urandom;
        d1 = $urandom;
        fork                                // both strobes rise in the same cycle
            bus_transfer(0, 1'b1, a0, d0, r0, e0, t0, ok0);
            bus_transfer(1, 1'b1, a1, d1, r1, e1, t1, ok1);
        join
        check_equal(32'(ok0 && ok1), 32'd1, "write ack lost");
        check_equal(32'(t0 < t1), 32'd1, "host 0 not acked first on write");
        check_equal(32'(e0), 32'd2, "host 0 write latency");
        if (ok0)
            model_write(a0, d0);
        if (ok1)
            model_write(a1, d1);
        fork
            bus_transfer(0, 1'b0, a1, '0, r0, e0, t0, ok0);
            bus_transfer(1, 1'b0, a0, '0, r1, e1, t1, ok1);
        join
        check_equal(32'(ok0 && ok1), 32'd1, "read ack lost");
        check_equal(32'(t0 < t1), 32'd1, "host 0 not acked first on read");
        check_equal(r0, model_read(a1), "host 0 read during contention");
        check_equal(r1, model_read(a0), "host 1 read during contention");
        finish_test("arbitration", err_before);
    endtask

    task automatic test_ack_timing();
        int    err_before;
        data_t rdat;
        int    edges;
        time   t_ack;
        bit    ok;
        err_before = error_count;
        for (int h = 0; h < HOST_COUNT; h++)
        begin
            bus_transfer(h, 1'b0, make_addr(h, 1), '0, rdat, edges, t_ack, ok);
            check_equal(32'(edges), 32'd2, "rising edges from strobe to ack");  // E0 and E1
            @(negedge sysclk);
            check_equal(32'(host_ack), 32'd0, "ack held longer than one cycle");
        end
        finish_test("ack_timing", err_before);
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial
    begin
        int rst_cycles;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        rst_cycles  = 0;
        for (int h = 0; h < HOST_COUNT; h++)
            host_in[h] = '0;
        for (int b = 0; b < NUM_BANKS; b++)
            for (int i = 0; i < REGS_PER_BANK; i++)
                model[b][i] = '0;           // registers clear on reset
        void'($urandom(SEED));
        while (!arst_n && rst_cycles < RST_TIMEOUT)
        begin
            @(posedge sysclk);
            rst_cycles++;
        end
        if (!arst_n)
        begin
            error_count++;
            $display("reset was never released");
        end
        else
        begin
            test_reset_values();
            test_write_read_all();
            test_isolation();
            test_arbitration();
            test_ack_timing();
        end
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* src.f */
src/bus_pkg.sv
src/addr_map_pkg.sv
src/host_arbiter.sv
src/reg_bank.sv
src/read_return.sv
src/board_bus_top.sv
testbench/tb_clock_gen.sv
testbench/tb_board_bus.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the board bus testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_board_bus \
    -Mdir obj_dir -o tb_board_bus
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_board_bus)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
